// ==== Bender.yml ====
package:
  name: fm_mixer

export_include_dirs:
  - logic

sources:
  - files:
      - logic/fm_sample_pkg.sv
      - logic/fm_slot_pkg.sv
      - logic/slot_sequencer.sv
      - logic/channel_regs.sv
      - logic/channel_accumulator.sv
      - logic/dac_float_model.sv
      - logic/fm_mixer_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/fm_mixer_tb.sv

// ==== bench/fm_mixer_tb.sv ====
// FM mixer testbench
`timescale 1ns/1ps
`include "fm_mix_consts.svh"

module fm_mixer_tb
    import fm_sample_pkg::*;
    import fm_slot_pkg::*;
();

    logic          clk;
    logic          rst_sum;
    logic          cen;
    logic          cfg_wr;
    cfg_addr_t     cfg_addr;
    cfg_data_t     cfg_data;
    op_sample_t    op_out;
    noise_sample_t noise_mix;
    slot_idx_t     slot;
    mix_sample_t   xleft;
    mix_sample_t   xright;
    mix_sample_t   left;
    mix_sample_t   right;
    logic          sample_strobe;

    logic [31:0]   lfsr_q;
    op_sample_t    frame_ops [`FM_SLOT_NUM];
    con_t          ref_con [`FM_CH_NUM];
    pan_t          ref_pan [`FM_CH_NUM];
    logic          ref_noise_en;
    int            prev_sums [`FM_CH_NUM];  // channel totals of the last frame driven
    int            frames_done;
    int            strobe_count;
    mix_sample_t   got_left;
    mix_sample_t   got_right;
    mix_sample_t   got_dac_left;
    mix_sample_t   got_dac_right;

    tb_clock_gen u_clk (
        .clk     (clk),
        .rst_sum (rst_sum)
    );

    fm_mixer_top uut (
        .clk           (clk),
        .rst_sum       (rst_sum),
        .cen           (cen),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .op_out        (op_out),
        .noise_mix     (noise_mix),
        .slot          (slot),
        .xleft         (xleft),
        .xright        (xright),
        .left          (left),
        .right         (right),
        .sample_strobe (sample_strobe)
    );

    // galois shift with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit)
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // groups in slot order C2, M1, M2, C1
    function automatic logic group_used(input con_t con, input int grp);
        case (grp)
            0:       return con >= 3'd5;
            1:       return con >= 3'd4;
            2:       return 1'b1;
            default: return con == 3'd7;
        endcase
    endfunction

    function automatic int sat_mix(input int v);
        if (v > 32767)
            return 32767;
        if (v < -32768)
            return -32768;
        return v;
    endfunction

    // what the DAC gives back for a 16 bit level
    function automatic int dac_level(input int v);
        int m;
        for (int e = 0; e <= 6; e++) begin
            m = v >>> e;
            if (m >= -512 && m <= 511)
                return m * (1 << e);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_mix(input string what, input mix_sample_t got,
                             input mix_sample_t expected);
        if (got !== expected)
            abort_run($sformatf("FAILED at %0.1f ns: %s is %0d, expected %0d",
                                $realtime, what, got, expected));
    endtask

    task automatic check_slot(input slot_idx_t got, input slot_idx_t expected);
        if (got !== expected)
            abort_run($sformatf("FAILED at %0.1f ns: slot is %0d, expected %0d",
                                $realtime, got, expected));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic note_strobe();
        if (sample_strobe) begin
            strobe_count++;
            got_left      = xleft;
            got_right     = xright;
            got_dac_left  = left;
            got_dac_right = right;
        end
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
        cfg_addr = addr;
        cfg_data = data;
        cfg_wr   = 1'b1;
        next_cycle();
        cfg_wr   = 1'b0;
    endtask

    task automatic set_channel(input int ch, input con_t con, input pan_t pan);
        write_cfg(cfg_addr_t'(ch), {pan, 3'b000, con});
        ref_con[ch] = con;
        ref_pan[ch] = pan;
    endtask

    task automatic set_noise(input logic en);
        write_cfg(cfg_addr_t'(`FM_CFG_NOISE_ADDR), {7'd0, en});
        ref_noise_en = en;
    endtask

    task automatic mute_all();
        for (int ch = 0; ch < `FM_CH_NUM; ch++)
            set_channel(ch, 3'd0, 2'b00);
    endtask

    task automatic fill_ops(input int v);
        for (int s = 0; s < `FM_SLOT_NUM; s++)
            frame_ops[s] = op_sample_t'(v);
    endtask

    // one cen cycle and then one idle cycle
    task automatic drive_slot(input op_sample_t v);
        op_out = v;
        cen    = 1'b1;
        next_cycle();
        note_strobe();
        cen    = 1'b0;
        next_cycle();
        note_strobe();
    endtask

    task automatic wait_reset_release();
        for (int i = 0; i < 50; i++) begin
            next_cycle();
            if (!rst_sum)
                return;
        end
        abort_run("reset was never released");
    endtask

    task automatic wait_slot_zero();
        for (int i = 0; i < 2 * `FM_SLOT_NUM; i++) begin
            if (slot == '0)
                return;
            drive_slot('0);
        end
        abort_run("slot counter never came back to slot 0");
    endtask

    // channel totals of frame_ops under the current config
    task automatic compute_sums();
        int acc;
        int s;
        int v;
        for (int ch = 0; ch < `FM_CH_NUM; ch++) begin
            acc = 0;
            for (int grp = 0; grp < 4; grp++) begin
                s = grp * `FM_CH_NUM + ch;
                v = frame_ops[s];
                if (ref_noise_en && s == `FM_SLOT_NUM - 1)
                    v = noise_mix;
                if (group_used(ref_con[ch], grp))
                    acc = sat_mix(acc + v);
            end
            prev_sums[ch] = acc;
        end
    endtask

    // drives one frame and checks the output of the frame before it
    task automatic run_frame();
        int exp_l;
        int exp_r;
        wait_slot_zero();
        exp_l = 0;
        exp_r = 0;
        for (int ch = 0; ch < `FM_CH_NUM; ch++) begin
            if (ref_pan[ch][0])
                exp_l += prev_sums[ch];
            if (ref_pan[ch][1])
                exp_r += prev_sums[ch];
        end
        exp_l = sat_mix(exp_l);
        exp_r = sat_mix(exp_r);
        strobe_count = 0;
        for (int s = 0; s < `FM_SLOT_NUM; s++) begin
            check_slot(slot, slot_idx_t'(s));
            drive_slot(frame_ops[s]);
        end
        if (frames_done == 0) begin
            if (strobe_count != 0)
                abort_run("sample_strobe came during the first frame after reset");
        end else if (strobe_count == 0) begin
            abort_run("timed out waiting for sample_strobe within the frame");
        end else if (strobe_count > 1) begin
            abort_run("sample_strobe came more than once in a frame");
        end else begin
            check_mix("xleft", got_left, mix_sample_t'(exp_l));
            check_mix("xright", got_right, mix_sample_t'(exp_r));
            check_mix("left", got_dac_left, mix_sample_t'(dac_level(exp_l)));
            check_mix("right", got_dac_right, mix_sample_t'(dac_level(exp_r)));
        end
        compute_sums();
        frames_done++;
    endtask

    task automatic reset_state();
        check_slot(slot, '0);
        check_mix("xleft", xleft, '0);
        check_mix("xright", xright, '0);
        check_mix("left", left, '0);
        check_mix("right", right, '0);
        fill_ops(0);
        run_frame();
        check_mix("xleft", xleft, '0);
        check_mix("xright", xright, '0);
    endtask

    task automatic single_channel();
        int v;
        v = 1234;
        mute_all();
        set_channel(3, 3'd7, 2'b11);
        for (int s = 0; s < `FM_SLOT_NUM; s++)
            frame_ops[s] = (s % 8 == 3) ? op_sample_t'(v) : op_sample_t'(s * 37 - 500);
        run_frame();
        run_frame();
        check_mix("xleft", xleft, mix_sample_t'(4 * v));
        check_mix("xright", xright, mix_sample_t'(4 * v));
    endtask

    task automatic gating_and_pan();
        mute_all();
        set_channel(0, 3'd0, 2'b01);  // left only
        set_channel(1, 3'd4, 2'b10);  // right only
        set_channel(2, 3'd5, 2'b11);
        set_channel(3, 3'd7, 2'b01);
        set_channel(5, 3'd6, 2'b11);
        for (int s = 0; s < `FM_SLOT_NUM; s++)
            frame_ops[s] = op_sample_t'((s / 8 + 1) * 1000 + (s % 8) * 10);
        run_frame();
        run_frame();
    endtask

    task automatic bus_saturation();
        for (int ch = 0; ch < `FM_CH_NUM; ch++)
            set_channel(ch, 3'd7, 2'b11);
        fill_ops(8191);
        run_frame();
        fill_ops(-8192);
        run_frame();
        fill_ops(0);
        run_frame();
    endtask

    task automatic noise_select();
        mute_all();
        set_channel(7, 3'd7, 2'b11);
        fill_ops(300);
        noise_mix = noise_sample_t'(-1000);
        set_noise(1'b1);
        run_frame();
        run_frame();
        set_noise(1'b0);
        run_frame();
        run_frame();
    endtask

    task automatic random_frames();
        logic [31:0] r;
        for (int f = 0; f < 6; f++) begin
            for (int ch = 0; ch < `FM_CH_NUM; ch++) begin
                r = rand_bits(5);
                set_channel(ch, con_t'(r[4:2]), pan_t'(r[1:0]));
            end
            r = rand_bits(1);
            set_noise(r[0]);
            noise_mix = noise_sample_t'(rand_bits(12));
            for (int s = 0; s < `FM_SLOT_NUM; s++)
                frame_ops[s] = op_sample_t'(rand_bits(14));
            run_frame();
        end
        fill_ops(0);
        run_frame();  // last random frame comes out here
    endtask

    initial begin
        lfsr_q       = 32'hc44;
        cen          = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        op_out       = '0;
        noise_mix    = '0;
        ref_noise_en = 1'b0;
        frames_done  = 0;
        strobe_count = 0;
        for (int ch = 0; ch < `FM_CH_NUM; ch++) begin
            ref_con[ch]   = '0;
            ref_pan[ch]   = '0;
            prev_sums[ch] = 0;
        end
        wait_reset_release();
        reset_state();
        single_channel();
        gating_and_pan();
        bus_saturation();
        noise_select();
        random_frames();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
// bench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_sum
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_sum = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst_sum = 1'b0;  // clear of the bench sampling point
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/fm_sample_pkg.sv
logic/fm_slot_pkg.sv
logic/slot_sequencer.sv
logic/channel_regs.sv
logic/channel_accumulator.sv
logic/dac_float_model.sv
logic/fm_mixer_top.sv
bench/tb_clock_gen.sv
bench/fm_mixer_tb.sv

// ==== logic/channel_accumulator.sv ====
// stereo channel accumulator
`timescale 1ns/1ps
`include "fm_mix_consts.svh"

module channel_accumulator
    import fm_sample_pkg::*;
    import fm_slot_pkg::*;
(
    input  logic          clk,
    input  logic          rst_sum,
    input  logic          cen,
    input  logic          m1_enters,
    input  logic          m2_enters,
    input  logic          c1_enters,
    input  logic          c2_enters,
    input  logic          noise_slot,
    input  logic          noise_en,
    input  pan_t          rl_sel,
    input  con_t          con_sel,
    input  op_sample_t    op_out,
    input  noise_sample_t noise_mix,
    output mix_sample_t   xleft,
    output mix_sample_t   xright,
    output logic          sample_strobe
);

    localparam mix_sample_t MIX_MAX = mix_sample_t'({1'b0, {(`FM_MIX_W-1){1'b1}}});
    localparam mix_sample_t MIX_MIN = mix_sample_t'({1'b1, {(`FM_MIX_W-1){1'b0}}});

    op_sample_t                op_val;
    logic                      sum_en;
    mix_sample_t               delay_q [`FM_CH_NUM];
    mix_sample_t               total;      // channel sum leaving the delay line
    wide_sum_t                 total_ex;
    logic signed [`FM_MIX_W:0] opsum_ext;  // one guard bit
    mix_sample_t               opsum;
    wide_sum_t                 pre_left;
    wide_sum_t                 pre_right;
    logic                      sum_all;     // bus holds this frame's channels
    logic                      first_latch_done;

    function automatic mix_sample_t clamp_mix(input wide_sum_t din);
        if (din[`FM_WIDE_W-1:`FM_MIX_W-1] == {(`FM_WIDE_W-`FM_MIX_W+1){din[`FM_MIX_W-1]}})
            return din[`FM_MIX_W-1:0];
        else
            return din[`FM_WIDE_W-1] ? MIX_MIN : MIX_MAX;
    endfunction

    // noise replaces the last operator of channel 7
    assign op_val = (noise_en && noise_slot) ?
                    {{(`FM_OP_W-`FM_NOISE_W){noise_mix[`FM_NOISE_W-1]}}, noise_mix} : op_out;

    // which groups feed the channel sum
    always_comb begin
        case (con_sel)
            3'd0, 3'd1, 3'd2, 3'd3: sum_en = m2_enters;
            3'd4:                   sum_en = m1_enters | m2_enters;
            3'd5, 3'd6:             sum_en = ~c1_enters;
            default:                sum_en = 1'b1;
        endcase
    end

    assign total     = delay_q[`FM_CH_NUM-1];
    assign total_ex  = wide_sum_t'(total);
    assign opsum_ext = op_val + total;

    // C2 starts a new sum and later groups add with saturation
    always_comb begin
        if (c2_enters) begin
            opsum = sum_en ? mix_sample_t'(op_val) : '0;
        end else if (!sum_en) begin
            opsum = total;
        end else if (opsum_ext[`FM_MIX_W] != opsum_ext[`FM_MIX_W-1]) begin
            opsum = opsum_ext[`FM_MIX_W] ? MIX_MIN : MIX_MAX;
        end else begin
            opsum = opsum_ext[`FM_MIX_W-1:0];
        end
    end

    // one stage per channel
    always_ff @(posedge clk) begin
        if (rst_sum) begin
            for (int i = 0; i < `FM_CH_NUM; i++) begin
                delay_q[i] <= '0;
            end
        end else if (cen) begin
            delay_q[0] <= opsum;
            for (int i = 1; i < `FM_CH_NUM; i++) begin
                delay_q[i] <= delay_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_sum) begin
            pre_left         <= '0;
            pre_right        <= '0;
            xleft            <= '0;
            xright           <= '0;
            sum_all          <= 1'b0;
            first_latch_done <= 1'b0;
            sample_strobe    <= 1'b0;
        end else begin
            sample_strobe <= 1'b0;  // single clk pulse
            if (cen) begin
                // previous frame totals come out during C2
                if (c2_enters) begin
                    sum_all <= 1'b1;
                    if (!sum_all) begin
                        pre_left  <= rl_sel[0] ? total_ex : '0;
                        pre_right <= rl_sel[1] ? total_ex : '0;
                    end else begin
                        pre_left  <= pre_left  + (rl_sel[0] ? total_ex : '0);
                        pre_right <= pre_right + (rl_sel[1] ? total_ex : '0);
                    end
                end
                if (c1_enters) begin
                    sum_all <= 1'b0;
                    xleft   <= clamp_mix(pre_left);
                    xright  <= clamp_mix(pre_right);
                    // first frame after reset carries no channel data
                    if (sum_all) begin
                        first_latch_done <= 1'b1;
                        sample_strobe    <= first_latch_done;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/channel_regs.sv ====
// channel configuration registers
`timescale 1ns/1ps
`include "fm_mix_consts.svh"

module channel_regs
    import fm_slot_pkg::*;
(
    input  logic      clk,
    input  logic      rst_sum,
    input  logic      cfg_wr,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_data,
    input  ch_idx_t   ch_idx,
    output con_t      con_sel,
    output pan_t      rl_sel,
    output logic      noise_en
);

    con_t con_q [`FM_CH_NUM];
    pan_t rl_q  [`FM_CH_NUM];

    logic ch_hit;
    logic noise_hit;

    // address decode
    assign ch_hit    = (cfg_addr < cfg_addr_t'(`FM_CH_NUM));
    assign noise_hit = (cfg_addr == cfg_addr_t'(`FM_CFG_NOISE_ADDR));

    // writes land on the next clk edge whatever cen does
    always_ff @(posedge clk) begin
        if (rst_sum) begin
            for (int i = 0; i < `FM_CH_NUM; i++) begin
                con_q[i] <= '0;
                rl_q[i]  <= '0;
            end
            noise_en <= 1'b0;
        end else if (cfg_wr) begin
            if (ch_hit) begin
                con_q[ch_idx_t'(cfg_addr)] <= cfg_data[2:0];
                rl_q[ch_idx_t'(cfg_addr)]  <= cfg_data[7:6];  // right, left
            end else if (noise_hit) begin
                noise_en <= cfg_data[0];
            end
        end
    end

    // settings of the channel currently in the slot
    assign con_sel = con_q[ch_idx];
    assign rl_sel  = rl_q[ch_idx];

endmodule

// ==== logic/dac_float_model.sv ====
// floating point DAC model
`timescale 1ns/1ps
`include "fm_mix_consts.svh"

module dac_float_model
    import fm_sample_pkg::*;
(
    input  mix_sample_t lin_in,
    output mantissa_t   man,
    output exponent_t   exp,
    output mix_sample_t lin_out
);

    // largest shift still leaves one sign bit above the mantissa
    localparam int MAX_SHIFT = `FM_MIX_W - `FM_MAN_W;

    mix_sample_t shifted;
    mix_sample_t man_wide;
    exponent_t   exp_sel;

    // search from the top down so the smallest fitting shift wins
    always_comb begin
        exp_sel = exponent_t'(MAX_SHIFT);
        shifted = lin_in;
        for (int e = MAX_SHIFT; e >= 0; e--) begin
            shifted = lin_in >>> e;
            if (shifted[`FM_MIX_W-1:`FM_MAN_W-1] ==
                {(`FM_MIX_W-`FM_MAN_W+1){shifted[`FM_MAN_W-1]}}) begin
                exp_sel = exponent_t'(e);
            end
        end
    end

    assign man_wide = lin_in >>> exp_sel;
    assign man      = man_wide[`FM_MAN_W-1:0];
    assign exp      = exp_sel;

    // expand back with the dropped low bits as zero
    assign lin_out  = mix_sample_t'(man) <<< exp_sel;

endmodule

// ==== logic/fm_mix_consts.svh ====
// fm mixer constants
`ifndef FM_MIX_CONSTS_SVH
`define FM_MIX_CONSTS_SVH

// sample widths
`define FM_OP_W           14  // operator output
`define FM_MIX_W          16  // channel sum and final output
`define FM_WIDE_W         19  // stereo bus before clamp
`define FM_NOISE_W        12  // noise generator output

// frame layout
`define FM_CH_NUM         8
`define FM_SLOT_NUM       32  // four operator groups of eight channels

// floating point DAC format
`define FM_MAN_W          10
`define FM_EXP_W          3

// channel registers sit at 0..7
`define FM_CFG_NOISE_ADDR 8

`endif

// ==== logic/fm_mixer_top.sv ====
// FM mixer output stage
`timescale 1ns/1ps

module fm_mixer_top
    import fm_sample_pkg::*;
    import fm_slot_pkg::*;
(
    input  logic          clk,
    input  logic          rst_sum,
    input  logic          cen,
    input  logic          cfg_wr,
    input  cfg_addr_t     cfg_addr,
    input  cfg_data_t     cfg_data,
    input  op_sample_t    op_out,
    input  noise_sample_t noise_mix,
    output slot_idx_t     slot,
    output mix_sample_t   xleft,
    output mix_sample_t   xright,
    output mix_sample_t   left,
    output mix_sample_t   right,
    output logic          sample_strobe
);

    ch_idx_t ch_idx;
    logic    c2_enters;
    logic    m1_enters;
    logic    m2_enters;
    logic    c1_enters;
    logic    noise_slot;
    con_t    con_sel;
    pan_t    rl_sel;
    logic    noise_en;

    slot_sequencer u_seq (
        .clk        (clk),
        .rst_sum    (rst_sum),
        .cen        (cen),
        .slot       (slot),
        .ch_idx     (ch_idx),
        .c2_enters  (c2_enters),
        .m1_enters  (m1_enters),
        .m2_enters  (m2_enters),
        .c1_enters  (c1_enters),
        .noise_slot (noise_slot)
    );

    channel_regs u_regs (
        .clk      (clk),
        .rst_sum  (rst_sum),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .ch_idx   (ch_idx),
        .con_sel  (con_sel),
        .rl_sel   (rl_sel),
        .noise_en (noise_en)
    );

    channel_accumulator u_acc (
        .clk           (clk),
        .rst_sum       (rst_sum),
        .cen           (cen),
        .m1_enters     (m1_enters),
        .m2_enters     (m2_enters),
        .c1_enters     (c1_enters),
        .c2_enters     (c2_enters),
        .noise_slot    (noise_slot),
        .noise_en      (noise_en),
        .rl_sel        (rl_sel),
        .con_sel       (con_sel),
        .op_out        (op_out),
        .noise_mix     (noise_mix),
        .xleft         (xleft),
        .xright        (xright),
        .sample_strobe (sample_strobe)
    );

    // the DAC word stays inside the chip
    dac_float_model left_dac (
        .lin_in  (xleft),
        .man     (),
        .exp     (),
        .lin_out (left)
    );

    dac_float_model right_dac (
        .lin_in  (xright),
        .man     (),
        .exp     (),
        .lin_out (right)
    );

endmodule

// ==== logic/fm_sample_pkg.sv ====
// audio sample types
`include "fm_mix_consts.svh"

package fm_sample_pkg;

    // operator core output for each slot
    typedef logic signed [`FM_OP_W-1:0]    op_sample_t;

    // noise generator output that replaces the last operator of channel 7
    typedef logic signed [`FM_NOISE_W-1:0] noise_sample_t;

    // channel totals and stereo outputs
    typedef logic signed [`FM_MIX_W-1:0]   mix_sample_t;

    // stereo bus wide enough for eight channel totals
    typedef logic signed [`FM_WIDE_W-1:0]  wide_sum_t;

    // DAC word
    typedef logic signed [`FM_MAN_W-1:0]   mantissa_t;
    typedef logic [`FM_EXP_W-1:0]          exponent_t;  // right shift of 0..6

endpackage

// ==== logic/fm_slot_pkg.sv ====
// slot and configuration types
`include "fm_mix_consts.svh"

package fm_slot_pkg;

    // position within the frame
    typedef logic [$clog2(`FM_SLOT_NUM)-1:0] slot_idx_t;
    typedef logic [$clog2(`FM_CH_NUM)-1:0]   ch_idx_t;

    // per channel settings
    typedef logic [2:0] con_t;  // connection algorithm 0..7
    typedef logic [1:0] pan_t;  // bit 1 right and bit 0 left

    // configuration port
    typedef logic [3:0] cfg_addr_t;
    typedef logic [7:0] cfg_data_t;

    // operator group from slot bits 4:3
    typedef enum logic [1:0] {
        GRP_C2 = 2'd0,
        GRP_M1 = 2'd1,
        GRP_M2 = 2'd2,
        GRP_C1 = 2'd3
    } op_group_e;

endpackage

// ==== logic/slot_sequencer.sv ====
// operator slot sequencer
`timescale 1ns/1ps
`include "fm_mix_consts.svh"

module slot_sequencer
    import fm_slot_pkg::*;
(
    input  logic      clk,
    input  logic      rst_sum,
    input  logic      cen,
    output slot_idx_t slot,
    output ch_idx_t   ch_idx,
    output logic      c2_enters,
    output logic      m1_enters,
    output logic      m2_enters,
    output logic      c1_enters,
    output logic      noise_slot
);

    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`FM_SLOT_NUM - 1);

    op_group_e group;

    // frame counter wraps 31 -> 0
    always_ff @(posedge clk) begin
        if (rst_sum) begin
            slot <= '0;
        end else if (cen) begin
            slot <= slot + slot_idx_t'(1);
        end
    end

    assign ch_idx = ch_idx_t'(slot);  // low bits pick the channel
    assign group  = op_group_e'(slot[$bits(slot_idx_t)-1 -: 2]);

    // one hot group strobes
    always_comb begin
        c2_enters = 1'b0;
        m1_enters = 1'b0;
        m2_enters = 1'b0;
        c1_enters = 1'b0;
        case (group)
            GRP_C2:  c2_enters = 1'b1;
            GRP_M1:  m1_enters = 1'b1;
            GRP_M2:  m2_enters = 1'b1;
            default: c1_enters = 1'b1;
        endcase
    end

    // C1 of channel 7 can carry noise instead
    assign noise_slot = (slot == LAST_SLOT);

endmodule
